//--- logic/umai_pkg.sv
package umai_pkg;

  // command fields
  // --------------------
  localparam int ADDR_W = 32;
  localparam int LEN_W  = 6;

  // packed command word, length sits above address
  localparam int CMD_W  = LEN_W + ADDR_W;

  // data beat
  // --------------------
  localparam int DATA_W = 512;
  localparam int LANES  = 2;
  localparam int LANE_W = DATA_W / LANES;

  // one beat, seen either as a flat word or as lanes
  // lane 0 is the low half of the word
  typedef union packed {
    logic [DATA_W-1:0]            word;
    logic [LANES-1:0][LANE_W-1:0] lane;
  } umai_beat_u;

endpackage

//--- logic/cdc_pkg.sv
package cdc_pkg;

  // flops in each gray pointer synchronizer
  localparam int SYNC_STAGES = 2;

  // default FIFO depths, powers of two
  localparam int CMD_DEPTH  = 8;  // command crossings
  localparam int DATA_DEPTH = 4;  // per data lane

endpackage

//--- logic/fifo_wr_ctrl.sv
module fifo_wr_ctrl #(
  parameter  int DEPTH = 8,
  localparam int AW    = $clog2(DEPTH)
) (
  input  logic          i_clk,
  input  logic          i_reset,

  input  logic          i_valid,
  input  logic [AW : 0] i_rd_ptr_gray,  // from read domain

  output logic          o_ready,
  output logic          o_wen,
  output logic [AW-1:0] o_waddr,
  output logic [AW : 0] o_wr_ptr_gray
);

  // full when the two top gray bits differ and the rest match
  localparam logic [AW:0] FULL_XOR = (AW+1)'(3 << (AW - 1));

  logic [AW:0] wr_bin;
  logic [AW:0] wr_bin_next;
  logic [AW:0] wr_gray;
  logic        full;

  // read pointer synchronizer, stage 0 takes the async input
  logic [cdc_pkg::SYNC_STAGES-1:0][AW:0] rd_sync;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      rd_sync <= '0;
    end else begin
      rd_sync <= {rd_sync[cdc_pkg::SYNC_STAGES-2:0], i_rd_ptr_gray};
    end
  end

  // write pointer
  // --------------------
  assign wr_bin_next = wr_bin + (AW+1)'(o_wen);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_next;
      wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);  // registered, glitch free
    end
  end

  assign full = (wr_gray ^ rd_sync[cdc_pkg::SYNC_STAGES-1]) == FULL_XOR;

  assign o_ready       = ~full;
  assign o_wen         = i_valid & o_ready;  // accepted push
  assign o_waddr       = wr_bin[AW-1:0];
  assign o_wr_ptr_gray = wr_gray;

endmodule

//--- logic/fifo_rd_ctrl.sv
module fifo_rd_ctrl #(
  parameter  int DEPTH = 8,
  localparam int AW    = $clog2(DEPTH)
) (
  input  logic          i_clk,
  input  logic          i_reset,

  input  logic          i_ready,
  input  logic [AW : 0] i_wr_ptr_gray,  // from write domain

  output logic          o_valid,
  output logic [AW-1:0] o_raddr,
  output logic [AW : 0] o_rd_ptr_gray
);

  logic [AW:0] rd_bin;
  logic [AW:0] rd_bin_next;
  logic [AW:0] rd_gray;
  logic        empty;
  logic        pop;

  // write pointer synchronizer
  logic [cdc_pkg::SYNC_STAGES-1:0][AW:0] wr_sync;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_sync <= '0;
    end else begin
      wr_sync <= {wr_sync[cdc_pkg::SYNC_STAGES-2:0], i_wr_ptr_gray};
    end
  end

  // read pointer
  // --------------------
  assign pop         = o_valid & i_ready;
  assign rd_bin_next = rd_bin + (AW+1)'(pop);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_next;
      rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
    end
  end

  // equal gray pointers, nothing left to read
  assign empty = rd_gray == wr_sync[cdc_pkg::SYNC_STAGES-1];

  assign o_valid       = ~empty;
  assign o_raddr       = rd_bin[AW-1:0];
  assign o_rd_ptr_gray = rd_gray;

endmodule

//--- logic/cdc_fifo.sv
module cdc_fifo #(
  parameter  int WIDTH = 32,
  parameter  int DEPTH = 8,   // power of two
  localparam int AW    = $clog2(DEPTH)
) (
  input  logic             i_wr_clk,
  input  logic             i_rd_clk,
  input  logic             i_reset,

  // write domain
  input  logic             i_valid,
  output logic             o_ready,
  input  logic [WIDTH-1:0] i_data,

  // read domain
  output logic             o_valid,
  input  logic             i_ready,
  output logic [WIDTH-1:0] o_data
);

  logic          wen;
  logic [AW-1:0] waddr;
  logic [AW-1:0] raddr;
  logic [AW : 0] wr_ptr_gray;
  logic [AW : 0] rd_ptr_gray;

  logic [WIDTH-1:0] mem [DEPTH];

  fifo_wr_ctrl #(
    .DEPTH (DEPTH)
  ) u_wr_ctrl (
    .i_clk         (i_wr_clk),
    .i_reset       (i_reset),
    .i_valid       (i_valid),
    .i_rd_ptr_gray (rd_ptr_gray),
    .o_ready       (o_ready),
    .o_wen         (wen),
    .o_waddr       (waddr),
    .o_wr_ptr_gray (wr_ptr_gray)
  );

  // storage, written in the write domain only
  always_ff @(posedge i_wr_clk) begin
    if (wen) begin
      mem[waddr] <= i_data;
    end
  end

  assign o_data = mem[raddr];  // fall-through, oldest entry

  fifo_rd_ctrl #(
    .DEPTH (DEPTH)
  ) u_rd_ctrl (
    .i_clk         (i_rd_clk),
    .i_reset       (i_reset),
    .i_ready       (i_ready),
    .i_wr_ptr_gray (wr_ptr_gray),
    .o_valid       (o_valid),
    .o_raddr       (raddr),
    .o_rd_ptr_gray (rd_ptr_gray)
  );

endmodule

//--- logic/umai_data_cdc.sv
module umai_data_cdc #(
  parameter int DEPTH = cdc_pkg::DATA_DEPTH
) (
  input  logic                 i_wr_clk,
  input  logic                 i_rd_clk,
  input  logic                 i_reset,

  // write domain
  input  logic                 i_valid,
  output logic                 o_ready,
  input  umai_pkg::umai_beat_u i_data,

  // read domain
  output logic                 o_valid,
  input  logic                 i_ready,
  output umai_pkg::umai_beat_u o_data
);

  logic [umai_pkg::LANES-1:0] lane_ready;
  logic [umai_pkg::LANES-1:0] lane_valid;
  logic                       push;
  logic                       pop;

  logic [umai_pkg::LANES-1:0][umai_pkg::LANE_W-1:0] rd_lane;

  // lanes move as one
  // --------------------
  assign o_ready = &lane_ready;  // space in every lane
  assign push    = i_valid & o_ready;

  assign o_valid = &lane_valid;  // data in every lane
  assign pop     = o_valid & i_ready;

  for (genvar g = 0; g < umai_pkg::LANES; g++) begin : g_lane
    cdc_fifo #(
      .WIDTH (umai_pkg::LANE_W),
      .DEPTH (DEPTH)
    ) u_lane_fifo (
      .i_wr_clk (i_wr_clk),
      .i_rd_clk (i_rd_clk),
      .i_reset  (i_reset),
      .i_valid  (push),
      .o_ready  (lane_ready[g]),
      .i_data   (i_data.lane[g]),
      .o_valid  (lane_valid[g]),
      .i_ready  (pop),
      .o_data   (rd_lane[g])
    );
  end

  // lanes back into one beat
  assign o_data.lane = rd_lane;

endmodule

//--- logic/umai_mst_afifo.sv
module umai_mst_afifo #(
  parameter int CMD_DEPTH  = cdc_pkg::CMD_DEPTH,
  parameter int DATA_DEPTH = cdc_pkg::DATA_DEPTH
) (
  input  logic                          i_bus_clk,
  input  logic                          i_ip_clk,
  input  logic                          i_reset,

  // bus side
  // --------------------
  input  logic                          i_bus_wcmd_valid,
  output logic                          o_bus_wcmd_ready,
  input  logic [umai_pkg::ADDR_W-1:0]   i_bus_wcmd_addr,
  input  logic [umai_pkg::LEN_W-1:0]    i_bus_wcmd_len,

  input  logic                          i_bus_rcmd_valid,
  output logic                          o_bus_rcmd_ready,
  input  logic [umai_pkg::ADDR_W-1:0]   i_bus_rcmd_addr,
  input  logic [umai_pkg::LEN_W-1:0]    i_bus_rcmd_len,

  input  logic                          i_bus_wvalid,
  output logic                          o_bus_wready,
  input  logic [umai_pkg::DATA_W-1:0]   i_bus_wdata,

  output logic                          o_bus_rvalid,
  input  logic                          i_bus_rready,
  output logic [umai_pkg::DATA_W-1:0]   o_bus_rdata,

  // ip side
  // --------------------
  output logic                          o_ip_wcmd_valid,
  input  logic                          i_ip_wcmd_ready,
  output logic [umai_pkg::ADDR_W-1:0]   o_ip_wcmd_addr,
  output logic [umai_pkg::LEN_W-1:0]    o_ip_wcmd_len,

  output logic                          o_ip_rcmd_valid,
  input  logic                          i_ip_rcmd_ready,
  output logic [umai_pkg::ADDR_W-1:0]   o_ip_rcmd_addr,
  output logic [umai_pkg::LEN_W-1:0]    o_ip_rcmd_len,

  output logic                          o_ip_wvalid,
  input  logic                          i_ip_wready,
  output logic [umai_pkg::DATA_W-1:0]   o_ip_wdata,

  input  logic                          i_ip_rvalid,
  output logic                          o_ip_rready,
  input  logic [umai_pkg::DATA_W-1:0]   i_ip_rdata
);

  logic [umai_pkg::CMD_W-1:0] wcmd_rdata;
  logic [umai_pkg::CMD_W-1:0] rcmd_rdata;

  // write command, bus to ip
  cdc_fifo #(
    .WIDTH (umai_pkg::CMD_W),
    .DEPTH (CMD_DEPTH)
  ) u_wcmd_fifo (
    .i_wr_clk (i_bus_clk),
    .i_rd_clk (i_ip_clk),
    .i_reset  (i_reset),
    .i_valid  (i_bus_wcmd_valid),
    .o_ready  (o_bus_wcmd_ready),
    .i_data   ({i_bus_wcmd_len, i_bus_wcmd_addr}),  // len above addr
    .o_valid  (o_ip_wcmd_valid),
    .i_ready  (i_ip_wcmd_ready),
    .o_data   (wcmd_rdata)
  );

  assign {o_ip_wcmd_len, o_ip_wcmd_addr} = wcmd_rdata;

  // read command, bus to ip
  cdc_fifo #(
    .WIDTH (umai_pkg::CMD_W),
    .DEPTH (CMD_DEPTH)
  ) u_rcmd_fifo (
    .i_wr_clk (i_bus_clk),
    .i_rd_clk (i_ip_clk),
    .i_reset  (i_reset),
    .i_valid  (i_bus_rcmd_valid),
    .o_ready  (o_bus_rcmd_ready),
    .i_data   ({i_bus_rcmd_len, i_bus_rcmd_addr}),
    .o_valid  (o_ip_rcmd_valid),
    .i_ready  (i_ip_rcmd_ready),
    .o_data   (rcmd_rdata)
  );

  assign {o_ip_rcmd_len, o_ip_rcmd_addr} = rcmd_rdata;

  // write data, bus to ip
  umai_data_cdc #(
    .DEPTH (DATA_DEPTH)
  ) u_wdata_cdc (
    .i_wr_clk (i_bus_clk),
    .i_rd_clk (i_ip_clk),
    .i_reset  (i_reset),
    .i_valid  (i_bus_wvalid),
    .o_ready  (o_bus_wready),
    .i_data   (i_bus_wdata),
    .o_valid  (o_ip_wvalid),
    .i_ready  (i_ip_wready),
    .o_data   (o_ip_wdata)
  );

  // read data, the other way round
  umai_data_cdc #(
    .DEPTH (DATA_DEPTH)
  ) u_rdata_cdc (
    .i_wr_clk (i_ip_clk),
    .i_rd_clk (i_bus_clk),
    .i_reset  (i_reset),
    .i_valid  (i_ip_rvalid),
    .o_ready  (o_ip_rready),
    .i_data   (i_ip_rdata),
    .o_valid  (o_bus_rvalid),
    .i_ready  (i_bus_rready),
    .o_data   (o_bus_rdata)
  );

endmodule

//--- dv/tb_umai_tasks.svh
// channels 0 to 3 are wcmd, rcmd, wdata and rdata
// the producer is the bus side except on rdata

task automatic stop_run(input string why);
  $display("%s", why);
  $display("TEST FAILED");
  $fatal(1, "run stopped at the first error");
endtask

task automatic check_value(
  input logic [511:0] got,
  input logic [511:0] exp,
  input string        what
);
  if (got !== exp) begin
    stop_run($sformatf("Fail at %0.1f ns: %s, got %0h, expected %0h",
                       $realtime, what, got, exp));
  end
endtask

// producer ready or consumer valid of one channel
function automatic logic flag_of(input logic is_ready, input int ch);
  logic [3:0] rdy;
  logic [3:0] vld;
  rdy = {o_ip_rready, o_bus_wready, o_bus_rcmd_ready, o_bus_wcmd_ready};
  vld = {o_bus_rvalid, o_ip_wvalid, o_ip_rcmd_valid, o_ip_wcmd_valid};
  return is_ready ? rdy[ch] : vld[ch];
endfunction

function automatic logic [511:0] data_of(input int ch);
  case (ch)
    0: return 512'({o_ip_wcmd_len, o_ip_wcmd_addr});  // len above addr
    1: return 512'({o_ip_rcmd_len, o_ip_rcmd_addr});
    2: return o_ip_wdata;
    default: return o_bus_rdata;
  endcase
endfunction

// random beat with differing lanes
function automatic logic [511:0] rand_item(input int ch);
  umai_pkg::umai_beat_u beat;
  int k;
  for (k = 0; k < umai_pkg::DATA_W / 32; k++) begin
    beat.word[k*32 +: 32] = $random(seed);
  end
  if (beat.lane[0] == beat.lane[1]) begin
    beat.lane[1] = ~beat.lane[0];
  end
  if (ch < 2) begin
    return 512'(beat.word[umai_pkg::CMD_W-1:0]);  // commands keep the low CMD_W bits
  end
  return beat.word;
endfunction

// one falling edge of the chosen domain
task automatic tick(input logic on_bus);
  if (on_bus) begin
    @(negedge i_bus_clk);
  end else begin
    @(negedge i_ip_clk);
  end
endtask

task automatic wait_flag(input logic is_ready, input int ch);
  int n;
  n = 0;
  // ready lives in the producer domain and valid in the consumer domain
  while (!flag_of(is_ready, ch) && n < TIMEOUT) begin
    tick(is_ready ^ (ch == 3));
    n++;
  end
  if (!flag_of(is_ready, ch)) begin
    stop_run($sformatf("timeout: no %s on channel %0d after %0d cycles",
                       is_ready ? "ready" : "valid", ch, TIMEOUT));
  end
endtask

task automatic drive(input int ch, input logic valid, input logic [511:0] d);
  {i_ip_rvalid, i_bus_wvalid, i_bus_rcmd_valid, i_bus_wcmd_valid} = 4'(valid) << ch;
  if (ch == 3) begin
    i_ip_rdata = d;
  end else begin
    {i_bus_wcmd_len, i_bus_wcmd_addr} = d[umai_pkg::CMD_W-1:0];
    {i_bus_rcmd_len, i_bus_rcmd_addr} = d[umai_pkg::CMD_W-1:0];
    i_bus_wdata = d;
  end
endtask

task automatic push(input int ch, input logic [511:0] d);
  tick(ch != 3);
  drive(ch, 1'b1, d);
  wait_flag(1'b1, ch);
  tick(ch != 3);  // accepted on the edge in between
  drive(ch, 1'b0, d);
endtask

task automatic pop(input int ch, output logic [511:0] d);
  tick(ch == 3);
  wait_flag(1'b0, ch);
  d = data_of(ch);  // fall-through output
  {i_bus_rready, i_ip_wready, i_ip_rcmd_ready, i_ip_wcmd_ready} = 4'b1 << ch;
  tick(ch == 3);
  {i_bus_rready, i_ip_wready, i_ip_rcmd_ready, i_ip_wcmd_ready} = '0;
endtask

// tests
// --------------------
task automatic reset_test();
  check_value(512'({o_ip_rready, o_bus_wready, o_bus_rcmd_ready, o_bus_wcmd_ready}),
              512'(4'hf), "ready outputs after reset");
  check_value(512'({o_bus_rvalid, o_ip_wvalid, o_ip_rcmd_valid, o_ip_wcmd_valid}),
              512'(0), "valid outputs after reset");
endtask

task automatic order_test(input int ch, input int count);
  logic [511:0] exp[$];
  logic [511:0] d;
  int n;
  for (n = 0; n < count; n++) begin
    d = rand_item(ch);
    exp.push_back(d);
    push(ch, d);
  end
  for (n = 0; n < count; n++) begin
    pop(ch, d);
    check_value(d, exp.pop_front(), $sformatf("channel %0d item %0d", ch, n));
  end
endtask

task automatic backpressure_test(input int ch, input int depth);
  logic [511:0] exp[$];
  logic [511:0] d;
  int n;
  // consumer ready stays low while valid is held high
  for (n = 0; n < 3 * depth; n++) begin
    tick(ch != 3);
    d = rand_item(ch);
    drive(ch, 1'b1, d);
    if (flag_of(1'b1, ch)) begin
      exp.push_back(d);  // taken on the next rising edge
    end
  end
  tick(ch != 3);
  drive(ch, 1'b0, d);
  check_value(512'(exp.size()), 512'(depth), $sformatf("channel %0d items accepted", ch));
  check_value(512'(flag_of(1'b1, ch)), 512'(0), $sformatf("channel %0d ready when full", ch));
  n = 0;
  while (exp.size() > 0) begin
    pop(ch, d);
    check_value(d, exp.pop_front(), $sformatf("channel %0d drained item %0d", ch, n));
    n++;
  end
  check_value(512'(flag_of(1'b0, ch)), 512'(0), $sformatf("channel %0d valid when empty", ch));
endtask

//--- dv/tb_umai_mst_afifo.sv
module tb_umai_mst_afifo;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CMD_DEPTH  = cdc_pkg::CMD_DEPTH;
  localparam int DATA_DEPTH = cdc_pkg::DATA_DEPTH;
  localparam int TIMEOUT    = 200;  // cycles of the waiting domain

  // channel numbers used by the transfer tasks
  localparam int CH_WCMD  = 0;
  localparam int CH_RCMD  = 1;
  localparam int CH_WDATA = 2;
  localparam int CH_RDATA = 3;

  int seed = 72;

  logic i_bus_clk = 1'b0;
  logic i_ip_clk  = 1'b0;
  logic i_reset;

  // valid and ready of all four channels
  logic i_bus_wcmd_valid, i_bus_rcmd_valid, i_bus_wvalid, i_bus_rready;
  logic o_bus_wcmd_ready, o_bus_rcmd_ready, o_bus_wready, o_bus_rvalid;
  logic o_ip_wcmd_valid, o_ip_rcmd_valid, o_ip_wvalid, o_ip_rready;
  logic i_ip_wcmd_ready, i_ip_rcmd_ready, i_ip_wready, i_ip_rvalid;

  // command fields
  logic [umai_pkg::ADDR_W-1:0] i_bus_wcmd_addr, i_bus_rcmd_addr;
  logic [umai_pkg::ADDR_W-1:0] o_ip_wcmd_addr, o_ip_rcmd_addr;
  logic [umai_pkg::LEN_W-1:0]  i_bus_wcmd_len, i_bus_rcmd_len;
  logic [umai_pkg::LEN_W-1:0]  o_ip_wcmd_len, o_ip_rcmd_len;

  // data beats
  logic [umai_pkg::DATA_W-1:0] i_bus_wdata, o_bus_rdata;
  logic [umai_pkg::DATA_W-1:0] o_ip_wdata, i_ip_rdata;

  // clocks
  // --------------------
  always #5 i_bus_clk = ~i_bus_clk;
  always #6.5 i_ip_clk = ~i_ip_clk;  // unrelated to the bus clock

  umai_mst_afifo #(
    .CMD_DEPTH  (CMD_DEPTH),
    .DATA_DEPTH (DATA_DEPTH)
  ) i_umai_mst_afifo (.*);

  `include "tb_umai_tasks.svh"

  // test sequence
  // --------------------
  initial begin
    i_reset = 1'b1;
    {i_bus_wcmd_valid, i_bus_rcmd_valid, i_bus_wvalid, i_bus_rready} = '0;
    {i_ip_wcmd_ready, i_ip_rcmd_ready, i_ip_wready, i_ip_rvalid} = '0;
    {i_bus_wcmd_addr, i_bus_wcmd_len, i_bus_rcmd_addr, i_bus_rcmd_len} = '0;
    i_bus_wdata = '0;
    i_ip_rdata  = '0;

    repeat (10) @(posedge i_bus_clk);
    @(negedge i_bus_clk);
    i_reset = 1'b0;  // both domains leave reset here

    reset_test();
    order_test(CH_WCMD, 5);
    order_test(CH_RCMD, 5);
    order_test(CH_WDATA, DATA_DEPTH);
    order_test(CH_RDATA, DATA_DEPTH);  // ip side to bus side
    backpressure_test(CH_WCMD, CMD_DEPTH);
    backpressure_test(CH_WDATA, DATA_DEPTH);

    $display("TEST OK");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+dv
logic/umai_pkg.sv
logic/cdc_pkg.sv
logic/fifo_wr_ctrl.sv
logic/fifo_rd_ctrl.sv
logic/cdc_fifo.sv
logic/umai_data_cdc.sv
logic/umai_mst_afifo.sv
dv/tb_umai_mst_afifo.sv

//--- Makefile
TOP := tb_umai_mst_afifo

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f verilog.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
